//--- hw/dcachePkg.sv
/*
 * Data cache package: geometry, controller states, memory-side opcodes
 * and the packed structs that connect the cache blocks.
 */
`default_nettype none

package dcachePkg;

  ////////////////////////////////////////
  // geometry
  ////////////////////////////////////////
  localparam int addrBits     = 16;
  localparam int wordBits     = 32;
  localparam int wordsPerLine = 4;
  localparam int numSets      = 16;
  localparam int numWays      = 2;
  // byte offset inside a line, word index inside a line
  localparam int offsetBits   = 4;
  localparam int wordSelBits  = 2;
  localparam int indexBits    = 4;
  localparam int tagBits      = addrBits - indexBits - offsetBits;
  localparam int lineBits     = wordsPerLine * wordBits;

  ////////////////////////////////////////
  // control encodings
  ////////////////////////////////////////
  typedef enum logic [2:0] {
    idle,
    lookup,
    evict,
    fetch,
    fill,
    finish,
    uncached
  } ctrlState;

  // what the line buffer puts on the memory bus
  typedef enum logic [2:0] {
    opNone,
    opFetch,
    opEvict,
    opUncachedRead,
    opUncachedWrite
  } busOp;

  ////////////////////////////////////////
  // port bundles
  ////////////////////////////////////////
  typedef struct packed {
    logic                sel;
    logic                enable;
    logic                write;
    logic [addrBits-1:0] addr;
    logic [wordBits-1:0] wdata;
  } apbReqT;

  typedef struct packed {
    logic                ready;
    logic [wordBits-1:0] rdata;
    logic                slverr;
  } apbRspT;

  typedef struct packed {
    logic                read;
    logic                write;
    logic [addrBits-1:0] addr;
    logic [wordBits-1:0] wdata;
  } memReqT;

  typedef struct packed {
    logic                ack;
    logic [wordBits-1:0] rdata;
  } memRspT;

  // controller to storage strobes
  typedef struct packed {
    logic lineWrite;
    logic wordWrite;
    logic advanceVictim;
  } wayCtrlT;

endpackage

`default_nettype wire

//--- hw/cacheCtrl.sv
/*
 * Cache controller FSM. Sequences hits, dirty evictions, line fills and
 * uncached single-word accesses, and raises APB ready at the end of each.
 */
`timescale 1ns/1ps
`default_nettype none

module cacheCtrl (
  input  logic               clk,
  input  logic               reset,
  input  dcachePkg::apbReqT  apbReq,
  input  logic               hit,
  input  logic               victimDirty,
  input  logic               lastWord,
  input  logic               ack,
  output dcachePkg::wayCtrlT wayCtl,
  output dcachePkg::busOp    op,
  output logic               ready
);

  dcachePkg::ctrlState state;
  dcachePkg::ctrlState nextState;

  logic uncachedAccess;
  logic setupPhase;
  logic lineDone;

  ////////////////////////////////////////
  // request decode
  ////////////////////////////////////////

  // top address bit selects the uncached window
  assign uncachedAccess = apbReq.addr[dcachePkg::addrBits-1];

  assign setupPhase = apbReq.sel & ~apbReq.enable;

  // last word of a line transfer, or the single uncached word, acknowledged
  assign lineDone = ack & lastWord;

  ////////////////////////////////////////
  // state register
  ////////////////////////////////////////
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      state <= dcachePkg::idle;
    end else begin
      state <= nextState;
    end
  end

  ////////////////////////////////////////
  // next state
  ////////////////////////////////////////
  always_comb begin
    nextState = state;
    case (state)
      dcachePkg::idle: begin
        if (setupPhase) begin
          nextState = dcachePkg::lookup;
        end
      end
      dcachePkg::lookup: begin
        if (uncachedAccess) begin
          nextState = dcachePkg::uncached;
        end else if (hit) begin
          nextState = dcachePkg::idle;
        end else if (victimDirty) begin
          nextState = dcachePkg::evict;
        end else begin
          nextState = dcachePkg::fetch;
        end
      end
      // write back the whole victim line first
      dcachePkg::evict: begin
        if (lineDone) begin
          nextState = dcachePkg::fetch;
        end
      end
      dcachePkg::fetch: begin
        if (lineDone) begin
          nextState = dcachePkg::fill;
        end
      end
      dcachePkg::fill: begin
        nextState = dcachePkg::finish;
      end
      dcachePkg::finish: begin
        nextState = dcachePkg::idle;
      end
      dcachePkg::uncached: begin
        if (lineDone) begin
          nextState = dcachePkg::finish;
        end
      end
      default: begin
        nextState = dcachePkg::idle;
      end
    endcase
  end

  ////////////////////////////////////////
  // outputs
  ////////////////////////////////////////
  always_comb begin
    op     = dcachePkg::opNone;
    wayCtl = '0;
    ready  = 1'b0;
    case (state)
      dcachePkg::lookup: begin
        // hit completes in the first access cycle
        if (!uncachedAccess && hit) begin
          ready            = 1'b1;
          wayCtl.wordWrite = apbReq.write;
        end
      end
      dcachePkg::evict: begin
        op = dcachePkg::opEvict;
      end
      dcachePkg::fetch: begin
        op = dcachePkg::opFetch;
      end
      dcachePkg::fill: begin
        // install the fetched line and move the round-robin pointer on
        wayCtl.lineWrite     = 1'b1;
        wayCtl.advanceVictim = 1'b1;
      end
      dcachePkg::finish: begin
        // line is resident now, so a cached write lands on the hit way
        ready            = 1'b1;
        wayCtl.wordWrite = apbReq.write & ~uncachedAccess;
      end
      dcachePkg::uncached: begin
        if (apbReq.write) begin
          op = dcachePkg::opUncachedWrite;
        end else begin
          op = dcachePkg::opUncachedRead;
        end
      end
      default: begin
        op = dcachePkg::opNone;
      end
    endcase
  end

endmodule

`default_nettype wire

//--- hw/wayArray.sv
/*
 * Two-way tag, valid, dirty and data storage. Combinational lookup and
 * victim read, clocked line and word writes, per-set round-robin victim.
 */
`timescale 1ns/1ps
`default_nettype none

module wayArray (
  input  logic                           clk,
  input  logic                           reset,
  input  logic [dcachePkg::addrBits-1:0] addr,
  input  logic [dcachePkg::wordBits-1:0] wdata,
  input  logic [dcachePkg::lineBits-1:0] fillLine,
  input  dcachePkg::wayCtrlT             wayCtl,
  output logic                           hit,
  output logic                           victimDirty,
  output logic [dcachePkg::wordBits-1:0] hitWord,
  output logic [dcachePkg::lineBits-1:0] victimLine,
  output logic [dcachePkg::tagBits-1:0]  victimTag
);

  // storage, indexed [way][set]
  logic [dcachePkg::tagBits-1:0]  tagMem  [dcachePkg::numWays][dcachePkg::numSets];
  logic [dcachePkg::lineBits-1:0] dataMem [dcachePkg::numWays][dcachePkg::numSets];

  // per-set status, one bit per way
  logic [dcachePkg::numWays-1:0] validBits [dcachePkg::numSets];
  logic [dcachePkg::numWays-1:0] dirtyBits [dcachePkg::numSets];
  logic [dcachePkg::numSets-1:0] victimPtr;

  logic [dcachePkg::indexBits-1:0]   setIdx;
  logic [dcachePkg::tagBits-1:0]     reqTag;
  logic [dcachePkg::wordSelBits-1:0] wordSel;
  logic [dcachePkg::numWays-1:0]     wayHit;
  logic                              hitWay;
  logic                              victimWay;

  assign wordSel = addr[dcachePkg::offsetBits-1 -: dcachePkg::wordSelBits];
  assign setIdx  = addr[dcachePkg::offsetBits +: dcachePkg::indexBits];
  assign reqTag  = addr[dcachePkg::addrBits-1 -: dcachePkg::tagBits];

  ////////////////////////////////////////
  // lookup
  ////////////////////////////////////////
  always_comb begin
    wayHit = '0;
    for (int w = 0; w < dcachePkg::numWays; w++) begin
      wayHit[w] = validBits[setIdx][w] && (tagMem[w][setIdx] == reqTag);
    end
  end

  assign hit    = |wayHit;
  // with two ways the hitting way is just the upper hit bit
  assign hitWay = wayHit[1];
  assign hitWord = dataMem[hitWay][setIdx][wordSel*dcachePkg::wordBits +: dcachePkg::wordBits];

  // victim side
  assign victimWay   = victimPtr[setIdx];
  assign victimLine  = dataMem[victimWay][setIdx];
  assign victimTag   = tagMem[victimWay][setIdx];
  assign victimDirty = validBits[setIdx][victimWay] & dirtyBits[setIdx][victimWay];

  ////////////////////////////////////////
  // tag and data writes
  ////////////////////////////////////////
  always_ff @(posedge clk) begin
    if (wayCtl.lineWrite) begin
      dataMem[victimWay][setIdx] <= fillLine;
      tagMem[victimWay][setIdx]  <= reqTag;
    end else if (wayCtl.wordWrite) begin
      dataMem[hitWay][setIdx][wordSel*dcachePkg::wordBits +: dcachePkg::wordBits] <= wdata;
    end
  end

  ////////////////////////////////////////
  // status bits and round-robin pointer
  ////////////////////////////////////////
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      for (int s = 0; s < dcachePkg::numSets; s++) begin
        validBits[s] <= '0;
        dirtyBits[s] <= '0;
      end
      victimPtr <= '0;
    end else begin
      if (wayCtl.lineWrite) begin
        // freshly fetched line is clean
        validBits[setIdx][victimWay] <= 1'b1;
        dirtyBits[setIdx][victimWay] <= 1'b0;
      end else if (wayCtl.wordWrite) begin
        dirtyBits[setIdx][hitWay] <= 1'b1;
      end
      if (wayCtl.advanceVictim) begin
        victimPtr[setIdx] <= ~victimPtr[setIdx];
      end
    end
  end

endmodule

`default_nettype wire

//--- hw/lineBuffer.sv
/*
 * Memory-side datapath: word counter, fill buffer, bus address and write
 * data generation, and the APB read-data select.
 */
`timescale 1ns/1ps
`default_nettype none

module lineBuffer (
  input  logic                           clk,
  input  logic                           reset,
  input  dcachePkg::busOp                op,
  input  logic [dcachePkg::addrBits-1:0] addr,
  input  logic [dcachePkg::wordBits-1:0] wdata,
  input  logic [dcachePkg::lineBits-1:0] victimLine,
  input  logic [dcachePkg::tagBits-1:0]  victimTag,
  input  logic [dcachePkg::wordBits-1:0] hitWord,
  input  dcachePkg::memRspT              memRsp,
  output dcachePkg::memReqT              memReq,
  output logic [dcachePkg::lineBits-1:0] fillLine,
  output logic                           lastWord,
  output logic [dcachePkg::wordBits-1:0] rdata
);

  localparam int byteBits = dcachePkg::offsetBits - dcachePkg::wordSelBits;

  logic [dcachePkg::wordSelBits-1:0] wordCount;
  logic [dcachePkg::indexBits-1:0]   setIdx;
  logic [dcachePkg::wordBits-1:0]    victimWord;
  logic [dcachePkg::wordBits-1:0]    heldWord;
  logic                              heldValid;
  logic                              ackSeen;
  logic                              uncachedOp;

  assign setIdx     = addr[dcachePkg::offsetBits +: dcachePkg::indexBits];
  assign victimWord = victimLine[wordCount*dcachePkg::wordBits +: dcachePkg::wordBits];
  assign uncachedOp = (op == dcachePkg::opUncachedRead) || (op == dcachePkg::opUncachedWrite);

  // an ack only counts while a strobe is up
  assign ackSeen  = memRsp.ack & (memReq.read | memReq.write);
  assign lastWord = (wordCount == dcachePkg::wordSelBits'(dcachePkg::wordsPerLine - 1)) |
                    uncachedOp;

  ////////////////////////////////////////
  // bus request
  ////////////////////////////////////////
  always_comb begin
    memReq       = '0;
    memReq.addr  = addr;
    memReq.wdata = wdata;
    case (op)
      dcachePkg::opFetch: begin
        memReq.read = 1'b1;
        memReq.addr = {addr[dcachePkg::addrBits-1:dcachePkg::offsetBits], wordCount,
                       {byteBits{1'b0}}};
      end
      dcachePkg::opEvict: begin
        // victim line goes back to its own address
        memReq.write = 1'b1;
        memReq.addr  = {victimTag, setIdx, wordCount, {byteBits{1'b0}}};
        memReq.wdata = victimWord;
      end
      dcachePkg::opUncachedRead:  memReq.read = 1'b1;
      dcachePkg::opUncachedWrite: memReq.write = 1'b1;
      default: memReq.read = 1'b0;
    endcase
  end

  // word counter, restarts whenever the bus goes quiet
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      wordCount <= '0;
      heldValid <= 1'b0;
    end else begin
      if (op == dcachePkg::opNone) begin
        wordCount <= '0;
      end else if (ackSeen) begin
        wordCount <= wordCount + 1'b1;
      end
      // finish follows the uncached ack by one cycle
      heldValid <= ackSeen & (op == dcachePkg::opUncachedRead);
    end
  end

  // fetched words and the uncached read word
  always_ff @(posedge clk) begin
    if (ackSeen && op == dcachePkg::opFetch) begin
      fillLine[wordCount*dcachePkg::wordBits +: dcachePkg::wordBits] <= memRsp.rdata;
    end
    if (ackSeen && op == dcachePkg::opUncachedRead) begin
      heldWord <= memRsp.rdata;
    end
  end

  assign rdata = heldValid ? heldWord : hitWord;

endmodule

`default_nettype wire

//--- hw/dcacheTop.sv
/*
 * L1 data cache top: APB completer toward the processor, word-wide
 * strobe/ack bus toward main memory.
 */
`timescale 1ns/1ps
`default_nettype none

module dcacheTop (
  input  logic              clk,
  input  logic              reset,
  input  dcachePkg::apbReqT apbReq,
  output dcachePkg::apbRspT apbRsp,
  output dcachePkg::memReqT memReq,
  input  dcachePkg::memRspT memRsp
);

  // request address as seen by storage and the memory datapath
  logic [dcachePkg::addrBits-1:0] reqAddr;

  // controller handshakes
  dcachePkg::wayCtrlT wayCtl;
  dcachePkg::busOp    op;
  logic               hit;
  logic               victimDirty;
  logic               lastWord;
  logic               ready;

  // datapath between storage and line buffer
  logic [dcachePkg::wordBits-1:0] hitWord;
  logic [dcachePkg::wordBits-1:0] readData;
  logic [dcachePkg::lineBits-1:0] victimLine;
  logic [dcachePkg::lineBits-1:0] fillLine;
  logic [dcachePkg::tagBits-1:0]  victimTag;

  assign reqAddr = apbReq.addr;

  cacheCtrl ctrl (
    .clk(clk),
    .reset(reset),
    .apbReq(apbReq),
    .hit(hit),
    .victimDirty(victimDirty),
    .lastWord(lastWord),
    .ack(memRsp.ack),
    .wayCtl(wayCtl),
    .op(op),
    .ready(ready)
  );

  wayArray ways (
    .clk(clk),
    .reset(reset),
    .addr(reqAddr),
    .wdata(apbReq.wdata),
    .fillLine(fillLine),
    .wayCtl(wayCtl),
    .hit(hit),
    .victimDirty(victimDirty),
    .hitWord(hitWord),
    .victimLine(victimLine),
    .victimTag(victimTag)
  );

  lineBuffer lineBuf (
    .clk(clk),
    .reset(reset),
    .op(op),
    .addr(reqAddr),
    .wdata(apbReq.wdata),
    .victimLine(victimLine),
    .victimTag(victimTag),
    .hitWord(hitWord),
    .memRsp(memRsp),
    .memReq(memReq),
    .fillLine(fillLine),
    .lastWord(lastWord),
    .rdata(readData)
  );

  // no access can fail, so slverr stays low
  assign apbRsp.ready  = ready;
  assign apbRsp.rdata  = readData;
  assign apbRsp.slverr = 1'b0;

endmodule

`default_nettype wire

//--- testbench/dcacheChecker.sv
/*
 * Data cache scoreboard. Keeps a shadow of main memory, checks APB read
 * data and every memory-bus word of a transfer, and counts errors.
 */
`timescale 1ns/1ps
`default_nettype none

module dcacheChecker (
  input  logic              clk,
  input  logic              reset,
  input  dcachePkg::apbReqT apbReq,
  input  dcachePkg::apbRspT apbRsp,
  input  dcachePkg::memReqT memReq,
  input  dcachePkg::memRspT memRsp,
  input  int                rowNum,
  input  logic [31:0]       expRdata,
  input  int                expReads,
  input  int                expWrites,
  input  logic [7:0]        expVictimTag,
  output int                errors,
  output int                rowsDone
);

  logic [31:0] shadow [16384];
  logic [15:0] readAddrs [$];
  logic [15:0] writeAddrs [$];
  logic        strobeSeen = 1'b0;
  logic        resetReported = 1'b0;
  int          errorCount = 0;
  int          rowCount = 0;
  int          errorsAtStart = 0;

  assign errors   = errorCount;
  assign rowsDone = rowCount;

  function automatic logic [31:0] initialWord(input logic [15:0] a);
    return {a, ~a};
  endfunction

  initial begin
    for (int i = 0; i < 16384; i++) begin
      shadow[i] = initialWord(16'(i * 4));
    end
  end

  task automatic checkValue(input string name, input logic [31:0] got,
                            input logic [31:0] want);
    if (got !== want) begin
      $display("ERROR at %0t ns: %s is %h, expected %h", $time, name, got, want);
      errorCount++;
    end
  endtask

  task automatic reportProblem(input string what);
    $display("row %0d at %0t ns: %s", rowNum, $time, what);
    errorCount++;
  endtask

  ////////////////////////////////////////
  // one acknowledged memory word
  ////////////////////////////////////////
  task automatic inspectBusWord();
    logic [15:0] wantAddr;
    if (memReq.write) begin
      if (readAddrs.size() != 0) begin
        reportProblem("write-back word seen after a fetch read");
      end
      if (apbReq.addr[15]) begin
        wantAddr = apbReq.addr;
        checkValue("memReq.wdata", memReq.wdata, apbReq.wdata);
      end else begin
        // victim line lies in the request's set with words ascending from 0
        wantAddr = {expVictimTag, apbReq.addr[7:4], 4'h0} + 16'(4 * writeAddrs.size());
        checkValue("memReq.wdata", memReq.wdata, shadow[wantAddr[15:2]]);
      end
      checkValue("memReq.addr", 32'(memReq.addr), 32'(wantAddr));
      writeAddrs.push_back(memReq.addr);
    end else begin
      if (apbReq.addr[15]) begin
        wantAddr = apbReq.addr;
      end else begin
        wantAddr = {apbReq.addr[15:4], 4'h0} + 16'(4 * readAddrs.size());
      end
      checkValue("memReq.addr", 32'(memReq.addr), 32'(wantAddr));
      readAddrs.push_back(memReq.addr);
    end
  endtask

  task automatic finishRow();
    logic [13:0] idx;
    idx = apbReq.addr[15:2];
    checkValue("apbRsp.slverr", 32'(apbRsp.slverr), 32'h0);
    if (apbReq.write) begin
      shadow[idx] = apbReq.wdata;
    end else begin
      if (shadow[idx] != expRdata) begin
        reportProblem("shadow memory and stimulus table disagree on read data");
      end
      checkValue("apbRsp.rdata", apbRsp.rdata, shadow[idx]);
    end
    if (readAddrs.size() != expReads) begin
      reportProblem($sformatf("saw %0d memory reads, expected %0d", readAddrs.size(), expReads));
    end
    if (writeAddrs.size() != expWrites) begin
      reportProblem($sformatf("saw %0d memory writes, expected %0d", writeAddrs.size(),
                              expWrites));
    end
    if (expReads == 0 && expWrites == 0 && strobeSeen) begin
      reportProblem("memory strobe raised during a cache hit");
    end
    $display("row %0d %s %h: %s", rowNum, apbReq.write ? "write" : "read ", apbReq.addr,
             (errorCount == errorsAtStart) ? "ok" : "FAILED");
    rowCount++;
  endtask

  always @(posedge clk) begin
    if (reset) begin
      checkValue("apbRsp.ready", 32'(apbRsp.ready), 32'h0);
      checkValue("memReq.read", 32'(memReq.read), 32'h0);
      checkValue("memReq.write", 32'(memReq.write), 32'h0);
    end else begin
      if (!resetReported) begin
        $display("reset: %s", (errorCount == 0) ? "ok" : "FAILED");
        resetReported = 1'b1;
      end
      // setup cycle opens a new transfer
      if (apbReq.sel && !apbReq.enable) begin
        readAddrs.delete();
        writeAddrs.delete();
        strobeSeen    = 1'b0;
        errorsAtStart = errorCount;
      end
      if (memReq.read || memReq.write) begin
        strobeSeen = 1'b1;
        if (memRsp.ack) begin
          inspectBusWord();
        end
      end
      if (apbRsp.ready && apbReq.sel && apbReq.enable) begin
        finishRow();
      end
    end
  end

endmodule

`default_nettype wire

//--- testbench/dcacheTb.sv
/*
 * Data cache testbench top: clock, reset, main memory model with a random
 * ack delay, and a stimulus table applied as APB transfers.
 */
`timescale 1ns/1ps
`default_nettype none

module dcacheTb;

  localparam int numRows      = 12;
  localparam int resetCycles  = 5;
  // a row costs at most an evict plus a fetch at the longest ack delay
  localparam int cycleLimit   = numRows * 60 + resetCycles;
  localparam int memWordCount = 16384;

  typedef struct packed {
    logic        write;
    logic [15:0] addr;
    logic [31:0] wdata;
    logic [31:0] rdata;
    logic [3:0]  reads;
    logic [3:0]  writes;
    logic [7:0]  victim;
  } rowT;

  logic              clk = 1'b0;
  logic              reset;
  dcachePkg::apbReqT apbReq;
  dcachePkg::apbRspT apbRsp;
  dcachePkg::memReqT memReq;
  dcachePkg::memRspT memRsp;

  rowT         rows [numRows];
  int          rowNum;
  logic [31:0] expRdata;
  int          expReads;
  int          expWrites;
  logic [7:0]  expVictimTag;
  int          errors;
  int          rowsDone;

  logic [31:0] memWords [memWordCount];
  int          seed;
  int          waitLeft;
  int          cycles = 0;

  always #50 clk = ~clk;

  dcacheTop dut (
    .clk(clk),
    .reset(reset),
    .apbReq(apbReq),
    .apbRsp(apbRsp),
    .memReq(memReq),
    .memRsp(memRsp)
  );

  dcacheChecker scoreboard (
    .clk(clk),
    .reset(reset),
    .apbReq(apbReq),
    .apbRsp(apbRsp),
    .memReq(memReq),
    .memRsp(memRsp),
    .rowNum(rowNum),
    .expRdata(expRdata),
    .expReads(expReads),
    .expWrites(expWrites),
    .expVictimTag(expVictimTag),
    .errors(errors),
    .rowsDone(rowsDone)
  );

  // address in the upper half, its inverse in the lower half
  function automatic logic [31:0] initialWord(input logic [15:0] a);
    return {a, ~a};
  endfunction

  task automatic loadTable();
    // write, address, write data, expected read data, memory reads, memory writes,
    // tag of the evicted line
    rows[0]  = {1'b0, 16'h0134, 32'h0,        32'h0134FECB, 4'd4, 4'd0, 8'h00};
    rows[1]  = {1'b1, 16'h0134, 32'hCAFE0001, 32'h0,        4'd0, 4'd0, 8'h00};
    rows[2]  = {1'b0, 16'h0134, 32'h0,        32'hCAFE0001, 4'd0, 4'd0, 8'h00};
    rows[3]  = {1'b0, 16'h0238, 32'h0,        32'h0238FDC7, 4'd4, 4'd0, 8'h00};
    rows[4]  = {1'b1, 16'h023C, 32'h12345678, 32'h0,        4'd0, 4'd0, 8'h00};
    // third tag in set 3 pushes out the first dirty line
    rows[5]  = {1'b0, 16'h0330, 32'h0,        32'h0330FCCF, 4'd4, 4'd4, 8'h01};
    rows[6]  = {1'b0, 16'h0134, 32'h0,        32'hCAFE0001, 4'd4, 4'd4, 8'h02};
    rows[7]  = {1'b1, 16'h8010, 32'hA5A5F00D, 32'h0,        4'd0, 4'd1, 8'h00};
    rows[8]  = {1'b0, 16'h8010, 32'h0,        32'hA5A5F00D, 4'd1, 4'd0, 8'h00};
    rows[9]  = {1'b1, 16'h0540, 32'h0BADBEEF, 32'h0,        4'd4, 4'd0, 8'h00};
    rows[10] = {1'b0, 16'h0540, 32'h0,        32'h0BADBEEF, 4'd0, 4'd0, 8'h00};
    rows[11] = {1'b0, 16'h023C, 32'h0,        32'h12345678, 4'd4, 4'd0, 8'h00};
  endtask

  // setup cycle followed by access cycles until ready
  task automatic runRow(input int r);
    @(negedge clk);
    rowNum        = r + 1;
    expRdata      = rows[r].rdata;
    expReads      = int'(rows[r].reads);
    expWrites     = int'(rows[r].writes);
    expVictimTag  = rows[r].victim;
    apbReq.sel    = 1'b1;
    apbReq.enable = 1'b0;
    apbReq.write  = rows[r].write;
    apbReq.addr   = rows[r].addr;
    apbReq.wdata  = rows[r].wdata;
    @(negedge clk);
    apbReq.enable = 1'b1;
    do begin
      @(posedge clk);
    end while (!apbRsp.ready);
    @(negedge clk);
    apbReq.sel    = 1'b0;
    apbReq.enable = 1'b0;
  endtask

  ////////////////////////////////////////
  // main memory model
  ////////////////////////////////////////
  initial begin
    memRsp = '0;
    seed   = 99;
    for (int i = 0; i < memWordCount; i++) begin
      memWords[i] = initialWord(16'(i * 4));
    end
    waitLeft = $unsigned($random(seed)) % 4;
    forever begin
      @(negedge clk);
      if (reset || memRsp.ack) begin
        // one word per ack and a fresh delay for the next word
        memRsp.ack = 1'b0;
        waitLeft   = $unsigned($random(seed)) % 4;
      end else if (memReq.read || memReq.write) begin
        if (waitLeft > 0) begin
          waitLeft = waitLeft - 1;
        end else begin
          if (memReq.write) begin
            memWords[memReq.addr[15:2]] = memReq.wdata;
          end else begin
            memRsp.rdata = memWords[memReq.addr[15:2]];
          end
          memRsp.ack = 1'b1;
        end
      end
    end
  end

  ////////////////////////////////////////
  // stimulus and end of run
  ////////////////////////////////////////
  initial begin
    reset        = 1'b1;
    apbReq       = '0;
    rowNum       = 0;
    expRdata     = '0;
    expReads     = 0;
    expWrites    = 0;
    expVictimTag = '0;
    loadTable();
    repeat (resetCycles) @(negedge clk);
    reset = 1'b0;
    for (int r = 0; r < numRows; r++) begin
      runRow(r);
    end
    repeat (2) @(negedge clk);
    $display("rows done %0d of %0d, errors %0d", rowsDone, numRows, errors);
    if (errors == 0 && rowsDone == numRows) begin
      $display("Regression passed");
    end else begin
      $display("Regression failed");
    end
    $finish;
  end

  always @(posedge clk) begin
    cycles = cycles + 1;
    if (cycles > cycleLimit) begin
      $display("TIMEOUT after %0d cycles, a transfer never completed", cycleLimit);
      $display("Regression failed");
      $finish;
    end
  end

endmodule

`default_nettype wire

//--- sim.f
hw/dcachePkg.sv
hw/cacheCtrl.sv
hw/wayArray.sv
hw/lineBuffer.sv
hw/dcacheTop.sv
testbench/dcacheChecker.sv
testbench/dcacheTb.sv

//--- Makefile
# Verilator build and regression run for the L1 data cache

VERILATOR ?= verilator
TOP       ?= dcacheTb
FILELIST  ?= sim.f
OBJDIR    ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing
PASS_TEXT ?= Regression passed

# every source named in the file list, header directories left out
SOURCES := $(shell grep -v '^+' $(FILELIST))
SIMBIN  := $(OBJDIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(SIMBIN)

# rebuilt only when a source or the file list changes
$(SIMBIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJDIR) -o V$(TOP)

# the log decides pass or fail
run: $(SIMBIN)
	./$(SIMBIN) | tee $(LOG)
	@grep -q "$(PASS_TEXT)" $(LOG) || (echo "simulation did not pass, see $(LOG)"; exit 1)

clean:
	rm -rf $(OBJDIR) $(LOG)
